//--- common/exec_pkg.sv
package exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // low two bits of funct3, read as mul* or div* by the unit that gets it
  typedef enum logic [1:0] {
    md_mul_div    = 2'b00,
    md_mulh_divu  = 2'b01,
    md_mulhsu_rem = 2'b10,
    md_mulhu_remu = 2'b11
  } muldiv_op_t;

  typedef enum logic [2:0] {
    sel_alu,
    sel_lui,
    sel_auipc,
    sel_link,  // jal and jalr write npc
    sel_mul,
    sel_div
  } res_sel_t;

  typedef struct packed {
    logic valid;
    reg_addr_t waddr;
    word_t rdata1;
    word_t rdata2;
    word_t imm;
    word_t pc;
    word_t npc;
    logic use_imm;
    alu_op_t alu_op;
    muldiv_op_t md_op;
    res_sel_t res_sel;
  } issue_t;

  typedef struct packed {
    logic wren;
    reg_addr_t waddr;
    word_t wdata;
  } wb_t;

  typedef struct packed {
    word_t rdata1;
    word_t rdata2;
    word_t imm;
    logic use_imm;
    alu_op_t alu_op;
  } alu_req_t;

  typedef struct packed {
    logic enable;
    muldiv_op_t op;
    word_t rdata1;
    word_t rdata2;
  } md_req_t;

  typedef struct packed {
    logic ready;
    word_t result;
  } md_rsp_t;

  typedef struct packed {
    issue_t ins;
    logic launched;  // the held mul or div has been sent to its unit
    logic mul_busy;
    logic div_busy;
    logic stall;
    wb_t wb;
  } stage_reg_t;

  localparam stage_reg_t init_stage_reg = '0;

endpackage

//--- logic/alu.sv
module alu (
  input exec_pkg::alu_req_t req,
  output exec_pkg::word_t res
);

  exec_pkg::word_t op_b;
  logic [4:0] shamt;

  always_comb begin
    op_b = req.use_imm ? req.imm : req.rdata2;
    shamt = op_b[4:0];  // only the low five bits count for shifts

    case (req.alu_op)
      exec_pkg::alu_add: begin
        res = req.rdata1 + op_b;
      end
      exec_pkg::alu_sub: begin
        res = req.rdata1 - op_b;
      end
      exec_pkg::alu_sll: begin
        res = req.rdata1 << shamt;
      end
      exec_pkg::alu_slt: begin
        res = {31'b0, $signed(req.rdata1) < $signed(op_b)};
      end
      exec_pkg::alu_sltu: begin
        res = {31'b0, req.rdata1 < op_b};
      end
      exec_pkg::alu_xor: begin
        res = req.rdata1 ^ op_b;
      end
      exec_pkg::alu_srl: begin
        res = req.rdata1 >> shamt;
      end
      exec_pkg::alu_sra: begin
        res = $signed(req.rdata1) >>> shamt;  // sign bit fills from the left
      end
      exec_pkg::alu_or: begin
        res = req.rdata1 | op_b;
      end
      exec_pkg::alu_and: begin
        res = req.rdata1 & op_b;
      end
      default: begin
        res = '0;
      end
    endcase
  end

endmodule

//--- muldiv/mul_unit.sv
module mul_unit #(
  parameter int XLEN_ITER = 1
) (
  input logic clk,
  input logic rst,
  input exec_pkg::md_req_t req,
  output exec_pkg::md_rsp_t rsp
);

  localparam int steps = 32 / XLEN_ITER;

  typedef enum logic [1:0] {
    idle,
    run,
    done
  } state_t;

  state_t state;
  logic [5:0] cnt;
  logic [63:0] acc;
  logic [63:0] mcand;
  exec_pkg::word_t mplier;
  exec_pkg::muldiv_op_t op;
  logic neg;

  logic sign1;
  logic sign2;
  logic [63:0] acc_next;
  logic [63:0] mcand_next;
  exec_pkg::word_t mplier_next;
  logic [63:0] product;

  always_comb begin
    sign1 = req.rdata1[31] & (req.op != exec_pkg::md_mulhu_remu);
    sign2 = req.rdata2[31] & (req.op == exec_pkg::md_mul_div
                              || req.op == exec_pkg::md_mulh_divu);
  end

  always_comb begin
    acc_next = acc;
    mcand_next = mcand;
    mplier_next = mplier;
    for (int i = 0; i < XLEN_ITER; i++) begin
      if (mplier_next[0] == 1) begin
        acc_next = acc_next + mcand_next;
      end
      mcand_next = mcand_next << 1;
      mplier_next = mplier_next >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      state <= idle;
      cnt <= '0;
    end else begin
      case (state)
        idle: begin
          if (req.enable == 1) begin
            state <= run;
            cnt <= '0;
          end
        end
        run: begin
          cnt <= cnt + 6'd1;
          if (cnt == 6'(steps - 1)) begin
            state <= done;
          end
        end
        default: begin
          state <= idle;  // done lasts a single cycle
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && req.enable == 1) begin
      acc <= '0;
      mcand <= {32'b0, sign1 ? -req.rdata1 : req.rdata1};
      mplier <= sign2 ? -req.rdata2 : req.rdata2;
      op <= req.op;
      neg <= sign1 ^ sign2;
    end else if (state == run) begin
      acc <= acc_next;
      mcand <= mcand_next;
      mplier <= mplier_next;
    end
  end

  always_comb begin
    product = neg ? -acc : acc;
    rsp.ready = state == done;
    rsp.result = (op == exec_pkg::md_mul_div) ? product[31:0] : product[63:32];
  end

  enable_when_idle: assert property (@(posedge clk) disable iff (rst == 0)
    req.enable |-> state == idle);

endmodule

//--- muldiv/div_unit.sv
module div_unit #(
  parameter int XLEN_ITER = 1
) (
  input logic clk,
  input logic rst,
  input exec_pkg::md_req_t req,
  output exec_pkg::md_rsp_t rsp
);

  localparam int steps = 32 / XLEN_ITER;

  typedef enum logic [1:0] {
    idle,
    run,
    fix,
    done
  } state_t;

  state_t state;
  logic [5:0] cnt;
  logic [32:0] rem;
  exec_pkg::word_t quo;
  exec_pkg::word_t dvsr;
  exec_pkg::word_t result;
  logic quo_neg;
  logic rem_neg;
  logic is_rem;
  logic by_zero;

  logic signed_op;
  logic sign1;
  logic sign2;
  logic [32:0] rem_next;
  exec_pkg::word_t quo_next;
  exec_pkg::word_t quo_fixed;
  exec_pkg::word_t rem_fixed;

  always_comb begin
    signed_op = req.op == exec_pkg::md_mul_div || req.op == exec_pkg::md_mulhsu_rem;
    sign1 = req.rdata1[31] & signed_op;
    sign2 = req.rdata2[31] & signed_op;
  end

  // quo starts as the dividend and fills with quotient bits from the right
  always_comb begin
    rem_next = rem;
    quo_next = quo;
    for (int i = 0; i < XLEN_ITER; i++) begin
      rem_next = {rem_next[31:0], quo_next[31]};
      quo_next = quo_next << 1;
      if (rem_next >= {1'b0, dvsr}) begin
        rem_next = rem_next - {1'b0, dvsr};
        quo_next[0] = 1'b1;
      end
    end
  end

  // the remainder of a zero divisor is the dividend once its sign is restored
  // min / -1 wraps to the dividend on its own, with a zero remainder
  always_comb begin
    quo_fixed = quo_neg ? -quo : quo;
    if (by_zero == 1) begin
      quo_fixed = '1;
    end
    rem_fixed = rem_neg ? -rem[31:0] : rem[31:0];
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      state <= idle;
      cnt <= '0;
    end else begin
      case (state)
        idle: begin
          if (req.enable == 1) begin
            state <= run;
            cnt <= '0;
          end
        end
        run: begin
          cnt <= cnt + 6'd1;
          if (cnt == 6'(steps - 1)) begin
            state <= fix;
          end
        end
        fix: begin
          state <= done;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && req.enable == 1) begin
      rem <= '0;
      quo <= sign1 ? -req.rdata1 : req.rdata1;
      dvsr <= sign2 ? -req.rdata2 : req.rdata2;
      quo_neg <= sign1 ^ sign2;
      rem_neg <= sign1;  // remainder takes the sign of the dividend
      is_rem <= req.op == exec_pkg::md_mulhsu_rem || req.op == exec_pkg::md_mulhu_remu;
      by_zero <= req.rdata2 == '0;
    end else if (state == run) begin
      rem <= rem_next;
      quo <= quo_next;
    end else if (state == fix) begin
      result <= is_rem ? rem_fixed : quo_fixed;
    end
  end

  always_comb begin
    rsp.ready = state == done;
    rsp.result = result;
  end

  enable_when_idle: assert property (@(posedge clk) disable iff (rst == 0)
    req.enable |-> state == idle);

  ready_one_cycle: assert property (@(posedge clk) disable iff (rst == 0)
    rsp.ready |=> !rsp.ready);

endmodule

//--- logic/execute_stage.sv
module execute_stage (
  input logic clk,
  input logic rst,
  input exec_pkg::issue_t issue,
  input logic clear,
  output logic stall,
  output exec_pkg::wb_t wb,
  output exec_pkg::alu_req_t alu_req,
  input exec_pkg::word_t alu_res,
  output exec_pkg::md_req_t mul_req,
  output exec_pkg::md_req_t div_req,
  input exec_pkg::md_rsp_t mul_rsp,
  input exec_pkg::md_rsp_t div_rsp
);

  exec_pkg::stage_reg_t r;
  exec_pkg::stage_reg_t rin;
  exec_pkg::stage_reg_t v;
  logic is_mul;
  logic is_div;

  always_comb begin
    v = r;

    if (r.stall == 0) begin
      v.ins = issue;
      v.launched = 0;
    end

    is_mul = v.ins.valid & (v.ins.res_sel == exec_pkg::sel_mul);
    is_div = v.ins.valid & (v.ins.res_sel == exec_pkg::sel_div);

    alu_req.rdata1 = v.ins.rdata1;
    alu_req.rdata2 = v.ins.rdata2;
    alu_req.imm = v.ins.imm;
    alu_req.use_imm = v.ins.use_imm;
    alu_req.alu_op = v.ins.alu_op;

    // a unit still draining a cleared op gets the new one once it is idle again
    mul_req.enable = is_mul & ~v.launched & ~r.mul_busy & ~clear;
    mul_req.op = v.ins.md_op;
    mul_req.rdata1 = v.ins.rdata1;
    mul_req.rdata2 = v.ins.rdata2;

    div_req.enable = is_div & ~v.launched & ~r.div_busy & ~clear;
    div_req.op = v.ins.md_op;
    div_req.rdata1 = v.ins.rdata1;
    div_req.rdata2 = v.ins.rdata2;

    v.stall = 0;
    v.wb.waddr = v.ins.waddr;
    v.wb.wren = v.ins.valid & (v.ins.waddr != '0);

    case (v.ins.res_sel)
      exec_pkg::sel_lui: begin
        v.wb.wdata = v.ins.imm;
      end
      exec_pkg::sel_auipc: begin
        v.wb.wdata = v.ins.pc + v.ins.imm;
      end
      exec_pkg::sel_link: begin
        v.wb.wdata = v.ins.npc;
      end
      default: begin
        v.wb.wdata = alu_res;
      end
    endcase

    if (is_mul == 1) begin
      if ((v.launched & mul_rsp.ready) == 1) begin
        v.wb.wdata = mul_rsp.result;
      end else begin
        v.stall = 1;
      end
    end else if (is_div == 1) begin
      if ((v.launched & div_rsp.ready) == 1) begin
        v.wb.wdata = div_rsp.result;
      end else begin
        v.stall = 1;
      end
    end

    if (mul_rsp.ready == 1) begin
      v.mul_busy = 0;
    end
    if (mul_req.enable == 1) begin
      v.mul_busy = 1;
    end
    if (div_rsp.ready == 1) begin
      v.div_busy = 0;
    end
    if (div_req.enable == 1) begin
      v.div_busy = 1;
    end
    v.launched = v.launched | mul_req.enable | div_req.enable;

    if ((v.stall | clear) == 1) begin
      v.wb.wren = 0;
    end

    if (clear == 1) begin
      v.stall = 0;  // busy flags stay set so a late ready is not taken
      v.ins.valid = 0;
      v.launched = 0;
    end

    rin = v;
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      r <= exec_pkg::init_stage_reg;
    end else begin
      r <= rin;
    end
  end

  assign stall = r.stall;
  assign wb = r.wb;

  no_write_to_x0: assert property (@(posedge clk) disable iff (rst == 0)
    wb.wren |-> wb.waddr != '0);

endmodule

//--- logic/execute_top.sv
module execute_top #(
  parameter int XLEN_ITER = 1
) (
  input logic clk,
  input logic rst,
  input exec_pkg::issue_t issue,
  input logic clear,
  output logic stall,
  output exec_pkg::wb_t wb
);

  exec_pkg::alu_req_t alu_req;
  exec_pkg::word_t alu_res;
  exec_pkg::md_req_t mul_req;
  exec_pkg::md_req_t div_req;
  exec_pkg::md_rsp_t mul_rsp;
  exec_pkg::md_rsp_t div_rsp;

  execute_stage stage_i (
    .clk(clk),
    .rst(rst),
    .issue(issue),
    .clear(clear),
    .stall(stall),
    .wb(wb),
    .alu_req(alu_req),
    .alu_res(alu_res),
    .mul_req(mul_req),
    .div_req(div_req),
    .mul_rsp(mul_rsp),
    .div_rsp(div_rsp)
  );

  alu alu_i (
    .req(alu_req),
    .res(alu_res)
  );

  mul_unit #(
    .XLEN_ITER(XLEN_ITER)
  ) mul_i (
    .clk(clk),
    .rst(rst),
    .req(mul_req),
    .rsp(mul_rsp)
  );

  div_unit #(
    .XLEN_ITER(XLEN_ITER)
  ) div_i (
    .clk(clk),
    .rst(rst),
    .req(div_req),
    .rsp(div_rsp)
  );

endmodule

//--- tests/execute_checker.sv
module execute_checker (
  input logic clk,
  input logic rst,
  input exec_pkg::issue_t issue,
  input logic clear,
  input logic stall,
  input exec_pkg::wb_t wb,
  input logic [127:0] test_name,
  input logic done,
  output int value_errors,
  output int other_errors
);

  typedef struct packed {
    logic [127:0] name;
    exec_pkg::reg_addr_t waddr;
    exec_pkg::word_t wdata;
  } expect_t;

  expect_t pending_q[$];
  expect_t head;
  expect_t item;
  logic md_pending;  // the newest queued entry still waits on a muldiv unit
  logic end_checked;
  logic stall_check;  // an issue was accepted on the previous edge
  logic stall_due;
  logic [127:0] stall_name;

  function automatic exec_pkg::word_t alu_expected(exec_pkg::issue_t i);
    exec_pkg::word_t b;
    b = i.use_imm ? i.imm : i.rdata2;
    case (i.alu_op)
      exec_pkg::alu_add: return i.rdata1 + b;
      exec_pkg::alu_sub: return i.rdata1 - b;
      exec_pkg::alu_sll: return i.rdata1 << b[4:0];
      exec_pkg::alu_slt: return {31'b0, $signed(i.rdata1) < $signed(b)};
      exec_pkg::alu_sltu: return {31'b0, i.rdata1 < b};
      exec_pkg::alu_xor: return i.rdata1 ^ b;
      exec_pkg::alu_srl: return i.rdata1 >> b[4:0];
      exec_pkg::alu_sra: return $signed(i.rdata1) >>> b[4:0];
      exec_pkg::alu_or: return i.rdata1 | b;
      default: return i.rdata1 & b;
    endcase
  endfunction

  // sign-extended operands multiplied mod 2^64 give the exact 64-bit product
  function automatic exec_pkg::word_t mul_expected(exec_pkg::issue_t i);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] prod;
    sa = {{32{i.rdata1[31]}}, i.rdata1};
    sb = {{32{i.rdata2[31]}}, i.rdata2};
    ua = {32'b0, i.rdata1};
    ub = {32'b0, i.rdata2};
    case (i.md_op)
      exec_pkg::md_mul_div: prod = ua * ub;
      exec_pkg::md_mulh_divu: prod = sa * sb;
      exec_pkg::md_mulhsu_rem: prod = sa * ub;
      default: prod = ua * ub;
    endcase
    if (i.md_op == exec_pkg::md_mul_div) begin
      return prod[31:0];
    end
    return prod[63:32];
  endfunction

  function automatic exec_pkg::word_t div_expected(exec_pkg::issue_t i);
    exec_pkg::word_t a;
    exec_pkg::word_t b;
    logic overflow;
    a = i.rdata1;
    b = i.rdata2;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (i.md_op)
      exec_pkg::md_mul_div: begin
        if (b == '0) begin
          return '1;
        end
        if (overflow == 1) begin
          return a;
        end
        return $signed(a) / $signed(b);
      end
      exec_pkg::md_mulh_divu: begin
        if (b == '0) begin
          return '1;
        end
        return a / b;
      end
      exec_pkg::md_mulhsu_rem: begin
        if (b == '0) begin
          return a;
        end
        if (overflow == 1) begin
          return '0;
        end
        return $signed(a) % $signed(b);  // takes the sign of the dividend
      end
      default: begin
        if (b == '0) begin
          return a;
        end
        return a % b;
      end
    endcase
  endfunction

  function automatic exec_pkg::word_t expected_wdata(exec_pkg::issue_t i);
    case (i.res_sel)
      exec_pkg::sel_lui: return i.imm;
      exec_pkg::sel_auipc: return i.pc + i.imm;
      exec_pkg::sel_link: return i.npc;
      exec_pkg::sel_mul: return mul_expected(i);
      exec_pkg::sel_div: return div_expected(i);
      default: return alu_expected(i);
    endcase
  endfunction

  always @(posedge clk) begin
    if (rst == 0) begin
      pending_q.delete();
      md_pending = 0;
      end_checked = 0;
      stall_check = 0;
      stall_due = 0;
      stall_name = '0;
      value_errors = 0;
      other_errors = 0;
    end else begin
      if (stall_check == 1 && stall != stall_due) begin
        $display("Fail %0s: expected stall=%0b, actual stall=%0b", stall_name,
                 stall_due, stall);
        value_errors++;
      end
      stall_check = 0;
      if (wb.wren == 1) begin
        if (pending_q.size() == 0) begin
          $display("writeback to x%0d arrived with no instruction outstanding", wb.waddr);
          other_errors++;
        end else begin
          head = pending_q.pop_front();
          if (wb.waddr != head.waddr || wb.wdata != head.wdata) begin
            $display("Fail %0s: expected x%0d=%08h, actual x%0d=%08h", head.name,
                     head.waddr, head.wdata, wb.waddr, wb.wdata);
            value_errors++;
          end
        end
      end
      if (clear == 1 && stall == 1 && md_pending == 1) begin
        void'(pending_q.pop_back());  // the held mul or div is killed
        md_pending = 0;
      end
      if (issue.valid == 1 && stall == 0 && clear == 0) begin
        // only a mul or div holds the stage, and it does so from the next cycle
        stall_check = 1;
        stall_due = issue.res_sel == exec_pkg::sel_mul || issue.res_sel == exec_pkg::sel_div;
        stall_name = test_name;
        md_pending = stall_due && issue.waddr != '0;
        if (issue.waddr != '0) begin
          item.name = test_name;
          item.waddr = issue.waddr;
          item.wdata = expected_wdata(issue);
          pending_q.push_back(item);
        end
      end
      if (done == 1 && end_checked == 0) begin
        end_checked = 1;
        if (pending_q.size() != 0) begin
          $display("%0d expected writebacks never arrived", pending_q.size());
          other_errors++;
        end
      end
    end
  end

endmodule

//--- tests/execute_tb.sv
module execute_tb;

  typedef struct packed {
    logic [127:0] name;
    exec_pkg::res_sel_t sel;
    exec_pkg::alu_op_t aop;
    exec_pkg::muldiv_op_t mop;
    exec_pkg::word_t a;
    exec_pkg::word_t b;
    exec_pkg::word_t imm;
    logic use_imm;
    logic rnd;  // operands and imm come from the lfsr
    exec_pkg::reg_addr_t waddr;
    logic [3:0] clear_after;  // cycles from acceptance to clear where 0 means no clear
  } entry_t;

  logic clk = 0;
  logic rst;
  exec_pkg::issue_t issue;
  logic clear;
  logic stall;
  exec_pkg::wb_t wb;
  logic [127:0] test_name;
  logic done;
  int value_errors;
  int other_errors;
  int cycles = 0;
  int cycle_limit = 40;
  exec_pkg::word_t lfsr = 32'hb339bd9a;
  entry_t stim[$];

  always #5 clk = ~clk;

  execute_top #(
    .XLEN_ITER(1)
  ) uut (
    .clk(clk),
    .rst(rst),
    .issue(issue),
    .clear(clear),
    .stall(stall),
    .wb(wb)
  );

  execute_checker watch (
    .clk(clk),
    .rst(rst),
    .issue(issue),
    .clear(clear),
    .stall(stall),
    .wb(wb),
    .test_name(test_name),
    .done(done),
    .value_errors(value_errors),
    .other_errors(other_errors)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1 that moves one step per bit
  function automatic logic next_lfsr_bit();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out == 1) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic exec_pkg::word_t random_word();
    exec_pkg::word_t w;
    for (int k = 0; k < 32; k++) begin
      w[k] = next_lfsr_bit();
    end
    return w;
  endfunction

  task automatic add_entry(input logic [127:0] name, input exec_pkg::res_sel_t sel,
                           input exec_pkg::alu_op_t aop, input exec_pkg::muldiv_op_t mop,
                           input exec_pkg::word_t a, input exec_pkg::word_t b,
                           input exec_pkg::word_t imm, input logic use_imm, input logic rnd,
                           input exec_pkg::reg_addr_t waddr, input logic [3:0] clear_after);
    entry_t e;
    e.name = name;
    e.sel = sel;
    e.aop = aop;
    e.mop = mop;
    e.a = a;
    e.b = b;
    e.imm = imm;
    e.use_imm = use_imm;
    e.rnd = rnd;
    e.waddr = waddr;
    e.clear_after = clear_after;
    stim.push_back(e);
  endtask

  task automatic build_table();
    exec_pkg::word_t x_a[3];
    exec_pkg::word_t x_b[3];
    x_a = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
    x_b = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000};
    add_entry("add wrap", exec_pkg::sel_alu, exec_pkg::alu_add, exec_pkg::md_mul_div,
              32'h7fff_ffff, 32'h1, '0, 1'b0, 1'b0, 5'd1, 4'd0);
    add_entry("sra negative", exec_pkg::sel_alu, exec_pkg::alu_sra, exec_pkg::md_mul_div,
              32'h8000_0010, 32'h4, '0, 1'b0, 1'b0, 5'd2, 4'd0);
    add_entry("sra by 31", exec_pkg::sel_alu, exec_pkg::alu_sra, exec_pkg::md_mul_div,
              32'h8000_0000, 32'd31, '0, 1'b0, 1'b0, 5'd3, 4'd0);
    add_entry("sll by 31", exec_pkg::sel_alu, exec_pkg::alu_sll, exec_pkg::md_mul_div,
              32'h1, 32'hffff_ffff, '0, 1'b0, 1'b0, 5'd4, 4'd0);
    add_entry("srl imm 31", exec_pkg::sel_alu, exec_pkg::alu_srl, exec_pkg::md_mul_div,
              32'hffff_ffff, '0, 32'd31, 1'b1, 1'b0, 5'd5, 4'd0);
    add_entry("slt mixed", exec_pkg::sel_alu, exec_pkg::alu_slt, exec_pkg::md_mul_div,
              32'hffff_ffff, 32'h1, '0, 1'b0, 1'b0, 5'd6, 4'd0);
    add_entry("sltu mixed", exec_pkg::sel_alu, exec_pkg::alu_sltu, exec_pkg::md_mul_div,
              32'hffff_ffff, 32'h1, '0, 1'b0, 1'b0, 5'd7, 4'd0);
    add_entry("sltu imm", exec_pkg::sel_alu, exec_pkg::alu_sltu, exec_pkg::md_mul_div,
              32'h0, '0, 32'hffff_ffff, 1'b1, 1'b0, 5'd8, 4'd0);
    for (int k = 0; k < 20; k++) begin
      add_entry("alu random", exec_pkg::sel_alu, exec_pkg::alu_op_t'(k % 10),
                exec_pkg::md_mul_div, '0, '0, '0, 1'(k / 10), 1'b1, 5'(k + 1), 4'd0);
    end
    add_entry("lui", exec_pkg::sel_lui, exec_pkg::alu_add, exec_pkg::md_mul_div,
              '0, '0, 32'h1234_5000, 1'b0, 1'b0, 5'd9, 4'd0);
    add_entry("auipc", exec_pkg::sel_auipc, exec_pkg::alu_add, exec_pkg::md_mul_div,
              '0, '0, 32'hffff_f000, 1'b0, 1'b0, 5'd10, 4'd0);
    add_entry("jal link", exec_pkg::sel_link, exec_pkg::alu_add, exec_pkg::md_mul_div,
              '0, '0, 32'h40, 1'b0, 1'b0, 5'd11, 4'd0);
    for (int k = 0; k < 20; k++) begin
      add_entry("mul extreme", exec_pkg::sel_mul, exec_pkg::alu_add,
                exec_pkg::muldiv_op_t'(k % 4), x_a[k % 5 % 3], x_b[k % 5 % 3], '0, 1'b0,
                1'((k % 5) / 3), 5'(k + 1), 4'd0);  // last two of every five are random
    end
    for (int k = 0; k < 20; k++) begin
      add_entry("div mixed", exec_pkg::sel_div, exec_pkg::alu_add, exec_pkg::muldiv_op_t'(k % 4),
                (k < 8) ? 32'h8000_0000 : 32'hffff_fff9, (k < 4) ? 32'h0 : 32'hffff_ffff, '0,
                1'b0, 1'(k >= 12), 5'(k + 1), 4'd0);  // zero divisor, min by -1, -7 by -1
    end
    add_entry("x0 alu", exec_pkg::sel_alu, exec_pkg::alu_add, exec_pkg::md_mul_div,
              32'h5, 32'h6, '0, 1'b0, 1'b0, 5'd0, 4'd0);
    add_entry("x0 mul", exec_pkg::sel_mul, exec_pkg::alu_add, exec_pkg::md_mul_div,
              32'h5, 32'h6, '0, 1'b0, 1'b0, 5'd0, 4'd0);
    add_entry("mul cleared", exec_pkg::sel_mul, exec_pkg::alu_add, exec_pkg::md_mulhu_remu,
              '0, '0, '0, 1'b0, 1'b1, 5'd12, 4'd5);
    add_entry("alu after clear", exec_pkg::sel_alu, exec_pkg::alu_xor, exec_pkg::md_mul_div,
              '0, '0, '0, 1'b0, 1'b1, 5'd13, 4'd0);
    add_entry("mul busy unit", exec_pkg::sel_mul, exec_pkg::alu_add, exec_pkg::md_mul_div,
              '0, '0, '0, 1'b0, 1'b1, 5'd14, 4'd0);
    add_entry("div cleared", exec_pkg::sel_div, exec_pkg::alu_add, exec_pkg::md_mul_div,
              '0, '0, '0, 1'b0, 1'b1, 5'd15, 4'd12);
    add_entry("alu after clear", exec_pkg::sel_alu, exec_pkg::alu_or, exec_pkg::md_mul_div,
              '0, '0, '0, 1'b1, 1'b1, 5'd16, 4'd0);
    add_entry("div clear early", exec_pkg::sel_div, exec_pkg::alu_add, exec_pkg::md_mulhsu_rem,
              '0, '0, '0, 1'b0, 1'b1, 5'd17, 4'd1);
    add_entry("div busy unit", exec_pkg::sel_div, exec_pkg::alu_add, exec_pkg::md_mulhsu_rem,
              32'hffff_fff9, 32'h2, '0, 1'b0, 1'b0, 5'd18, 4'd0);
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic apply(input entry_t t, input int idx);
    exec_pkg::issue_t i;
    i = '0;
    i.valid = 1'b1;
    i.waddr = t.waddr;
    i.rdata1 = t.a;
    i.rdata2 = t.b;
    i.imm = t.imm;
    if (t.rnd == 1) begin
      i.rdata1 = random_word();
      i.rdata2 = random_word();
      i.imm = random_word();
    end
    i.pc = 32'h0000_1000 + 32'(idx * 4);
    i.npc = i.pc + 32'd4;
    i.use_imm = t.use_imm;
    i.alu_op = t.aop;
    i.md_op = t.mop;
    i.res_sel = t.sel;
    issue = i;
    test_name = t.name;
    while (stall == 1) begin
      @(negedge clk);
    end
    @(negedge clk);
    if (t.clear_after != 0) begin
      issue.valid = 1'b0;
      repeat (int'(t.clear_after) - 1) begin
        @(negedge clk);
      end
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    rst = 1'b0;
    clear = 1'b0;
    done = 1'b0;
    issue = '0;
    test_name = '0;
    build_table();
    cycle_limit = stim.size() * 40;
    repeat (2) begin
      @(negedge clk);
    end
    rst = 1'b1;
    foreach (stim[k]) begin
      apply(stim[k], k);
    end
    issue.valid = 1'b0;
    while (stall == 1) begin
      @(negedge clk);
    end
    repeat (3) begin
      @(negedge clk);
    end
    done = 1'b1;
    @(negedge clk);
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
common/exec_pkg.sv
logic/alu.sv
muldiv/mul_unit.sv
muldiv/div_unit.sv
logic/execute_stage.sv
logic/execute_top.sv
tests/execute_checker.sv
tests/execute_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= execute_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
PASS_TEXT = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status of the pipeline is the status of grep
run: compile
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
